/* design/axis_profile.sv */
`timescale 1ns/1ps

module axis_profile (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              tick,
    input  motion_pkg::data_t vel,
    input  motion_pkg::data_t acc,
    output logic              step_stb,
    output logic              dir,
    output motion_pkg::data_t pos
);
    import motion_pkg::*;

    pos_t  pos_q;
    data_t vel_q;
    data_t acc_q;
    logic  tick_d;
    logic  bit_before;       // STEP_BIT ahead of the last update

    assign pos = pos_q[POS_W-1:STEP_BIT];

    always_ff @(posedge clk) begin
        if (start) begin
            vel_q <= vel;
            acc_q <= acc;
        end else if (tick) begin
            vel_q <= vel_q + acc_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos_q      <= '0;
            tick_d     <= 1'b0;
            bit_before <= 1'b0;
            step_stb   <= 1'b0;
            dir        <= 1'b0;
        end else begin
            tick_d   <= tick;
            step_stb <= tick_d && (pos_q[STEP_BIT] != bit_before);
            if (tick) begin
                pos_q      <= pos_q + pos_t'(vel_q);   // Sign extended
                bit_before <= pos_q[STEP_BIT];
                dir        <= !vel_q[DATA_W-1];        // High when moving up
            end
        end
    end

endmodule

/* design/endstop_guard.sv */
`timescale 1ns/1ps

module endstop_guard (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  endstop,
    input  logic                  unlock,
    input  motion_pkg::axis_sel_t es_sel,
    input  logic                  es_polarity,
    input  logic                  es_enable,
    input  motion_pkg::data_t     pos [motion_pkg::NUM_AXES],
    output logic                  abort,
    output motion_pkg::data_t     es_pos
);
    import motion_pkg::*;

    logic sync_0;
    logic sync_1;
    logic match;

    assign match = es_enable && (sync_1 == es_polarity);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_0 <= 1'b0;
            sync_1 <= 1'b0;
            abort  <= 1'b0;
            es_pos <= '0;
        end else begin
            sync_0 <= endstop;
            sync_1 <= sync_0;
            if (match && !abort) begin
                abort  <= 1'b1;
                es_pos <= (es_sel < NUM_AXES) ? pos[es_sel] : '0;
            end else if (abort && unlock && !match) begin
                abort <= 1'b0;       // Only once the switch is clear
            end
        end
    end

endmodule

/* design/motion_pkg.sv */
package motion_pkg;

    localparam int NUM_AXES    = 3;
    localparam int NUM_MOTORS  = 3;
    localparam int DATA_W      = 32;
    localparam int POS_W       = 64;
    localparam int STEP_BIT    = 32;   // Integer part starts here
    localparam int DELAY_W     = 8;
    localparam int ADDR_W      = 8;
    localparam int MOTOR_CFG_W = 4;    // enable, select[1:0], invert

    localparam logic [ADDR_W-1:0] ADDR_CTRL     = 8'h00;
    localparam logic [ADDR_W-1:0] ADDR_DT       = 8'h04;
    localparam logic [ADDR_W-1:0] ADDR_STEPS    = 8'h08;
    localparam logic [ADDR_W-1:0] ADDR_REMAIN   = 8'h0C;
    localparam logic [ADDR_W-1:0] ADDR_PULSE    = 8'h10;
    localparam logic [ADDR_W-1:0] ADDR_MOTOR    = 8'h14;
    localparam logic [ADDR_W-1:0] ADDR_ENDSTOP  = 8'h18;
    localparam logic [ADDR_W-1:0] ADDR_VEL_BASE = 8'h20;
    localparam logic [ADDR_W-1:0] ADDR_ACC_BASE = 8'h24;
    localparam logic [ADDR_W-1:0] ADDR_POS_BASE = 8'h40;
    localparam logic [ADDR_W-1:0] ADDR_ES_POS   = 8'h50;

    localparam int AXIS_STRIDE = 8;    // vel/acc pair per axis
    localparam int POS_STRIDE  = 4;

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [POS_W-1:0]  pos_t;
    typedef logic [1:0]               axis_sel_t;
    typedef logic [DELAY_W-1:0]       delay_t;

endpackage

/* design/motion_regs.sv */
`timescale 1ns/1ps

module motion_regs (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [motion_pkg::ADDR_W-1:0]       paddr,
    input  logic [motion_pkg::DATA_W-1:0]       pwdata,
    output logic [motion_pkg::DATA_W-1:0]       prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  motion_pkg::data_t                   remain,
    input  logic                                busy,
    input  logic                                done,
    input  logic                                aborted,
    input  logic                                missed,
    input  motion_pkg::data_t                   pos [motion_pkg::NUM_AXES],
    input  motion_pkg::data_t                   es_pos,
    output logic                                start,
    output logic                                unlock,
    output motion_pkg::data_t                   dt,
    output motion_pkg::data_t                   steps,
    output motion_pkg::data_t                   vel [motion_pkg::NUM_AXES],
    output motion_pkg::data_t                   acc [motion_pkg::NUM_AXES],
    output motion_pkg::delay_t                  pre_n,
    output motion_pkg::delay_t                  pulse_n,
    output motion_pkg::delay_t                  post_n,
    output logic [motion_pkg::MOTOR_CFG_W*motion_pkg::NUM_MOTORS-1:0] motor_cfg,
    output motion_pkg::axis_sel_t               es_sel,
    output logic                                es_polarity,
    output logic                                es_enable
);
    import motion_pkg::*;

    localparam int MCFG_TOTAL = MOTOR_CFG_W * NUM_MOTORS;

    logic wr_en;
    logic ctrl_wr;
    logic addr_ok;

    assign pready  = 1'b1;            // No wait states
    assign pslverr = psel && penable && !addr_ok;
    assign wr_en   = psel && penable && pwrite && addr_ok;
    assign ctrl_wr = wr_en && (paddr == ADDR_CTRL);

    // Readback mux and address decode
    always_comb begin
        prdata  = '0;
        addr_ok = 1'b1;
        case (paddr)
            ADDR_CTRL:    prdata = {28'd0, missed, aborted, done, busy};
            ADDR_DT:      prdata = dt;
            ADDR_STEPS:   prdata = steps;
            ADDR_REMAIN:  prdata = remain;
            ADDR_PULSE:   prdata = {8'd0, post_n, pulse_n, pre_n};
            ADDR_MOTOR:   prdata = DATA_W'(motor_cfg);
            ADDR_ENDSTOP: prdata = {28'd0, es_enable, es_polarity, es_sel};
            ADDR_ES_POS:  prdata = es_pos;
            default:      addr_ok = 1'b0;
        endcase
        for (int i = 0; i < NUM_AXES; i++) begin
            if (paddr == ADDR_VEL_BASE + ADDR_W'(AXIS_STRIDE * i)) begin
                prdata  = vel[i];
                addr_ok = 1'b1;
            end
            if (paddr == ADDR_ACC_BASE + ADDR_W'(AXIS_STRIDE * i)) begin
                prdata  = acc[i];
                addr_ok = 1'b1;
            end
            if (paddr == ADDR_POS_BASE + ADDR_W'(POS_STRIDE * i)) begin
                prdata  = pos[i];
                addr_ok = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start       <= 1'b0;
            unlock      <= 1'b0;
            dt          <= '0;
            steps       <= '0;
            pre_n       <= '0;
            pulse_n     <= '0;
            post_n      <= '0;
            motor_cfg   <= '0;       // All motors disabled
            es_sel      <= '0;
            es_polarity <= 1'b0;
            es_enable   <= 1'b0;
            for (int i = 0; i < NUM_AXES; i++) begin
                vel[i] <= '0;
                acc[i] <= '0;
            end
        end else begin
            start  <= ctrl_wr && pwdata[0];
            unlock <= ctrl_wr && pwdata[1];
            if (wr_en) begin
                case (paddr)
                    ADDR_DT:    dt <= pwdata;
                    ADDR_STEPS: steps <= pwdata;
                    ADDR_PULSE: begin
                        pre_n   <= pwdata[7:0];
                        pulse_n <= pwdata[15:8];
                        post_n  <= pwdata[23:16];
                    end
                    ADDR_MOTOR: motor_cfg <= pwdata[MCFG_TOTAL-1:0];
                    ADDR_ENDSTOP: begin
                        es_sel      <= pwdata[1:0];
                        es_polarity <= pwdata[2];
                        es_enable   <= pwdata[3];
                    end
                    default: ;            // Read-only or strobe address
                endcase
                for (int i = 0; i < NUM_AXES; i++) begin
                    if (paddr == ADDR_VEL_BASE + ADDR_W'(AXIS_STRIDE * i))
                        vel[i] <= pwdata;
                    if (paddr == ADDR_ACC_BASE + ADDR_W'(AXIS_STRIDE * i))
                        acc[i] <= pwdata;
                end
            end
        end
    end

    a_apb_setup: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> psel);

endmodule

/* design/motion_top.sv */
`timescale 1ns/1ps

module motion_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [motion_pkg::ADDR_W-1:0]     paddr,
    input  logic [motion_pkg::DATA_W-1:0]     pwdata,
    output logic [motion_pkg::DATA_W-1:0]     prdata,
    output logic                              pready,
    output logic                              pslverr,
    input  logic                              endstop,
    output logic [motion_pkg::NUM_MOTORS-1:0] mot_step,
    output logic [motion_pkg::NUM_MOTORS-1:0] mot_dir,
    output logic [motion_pkg::NUM_MOTORS-1:0] mot_enable_n
);
    import motion_pkg::*;

    logic      start;
    logic      unlock;
    logic      tick;
    logic      busy;
    logic      done;
    logic      abort;
    logic      missed_any;
    data_t     dt;
    data_t     steps;
    data_t     remain;
    data_t     es_pos;
    data_t     vel [NUM_AXES];
    data_t     acc [NUM_AXES];
    data_t     pos [NUM_AXES];
    delay_t    pre_n;
    delay_t    pulse_n;
    delay_t    post_n;
    axis_sel_t es_sel;
    logic      es_polarity;
    logic      es_enable;

    logic [MOTOR_CFG_W*NUM_MOTORS-1:0] motor_cfg;
    logic [NUM_AXES-1:0] stb;        // Profile to pulse generator
    logic [NUM_AXES-1:0] stb_dir;
    logic [NUM_AXES-1:0] axis_step;
    logic [NUM_AXES-1:0] axis_dir;
    logic [NUM_AXES-1:0] missed;

    assign missed_any = |missed;

    motion_regs u_regs (
        .aborted (abort),
        .missed  (missed_any),
        .*
    );

    step_timer u_timer (.*);

    for (genvar a = 0; a < NUM_AXES; a++) begin : g_axis
        axis_profile u_profile (
            .clk      (clk),
            .rst_n    (rst_n),
            .start    (start),
            .tick     (tick),
            .vel      (vel[a]),
            .acc      (acc[a]),
            .step_stb (stb[a]),
            .dir      (stb_dir[a]),
            .pos      (pos[a])
        );

        step_pulse_fsm u_pulse (
            .clk      (clk),
            .rst_n    (rst_n),
            .start    (start),
            .step_stb (stb[a]),
            .step_dir (stb_dir[a]),
            .pre_n    (pre_n),
            .pulse_n  (pulse_n),
            .post_n   (post_n),
            .step     (axis_step[a]),
            .dir      (axis_dir[a]),
            .missed   (missed[a])
        );
    end

    motor_router u_router (.*);

    endstop_guard u_endstop (.*);

endmodule

/* design/motor_router.sv */
`timescale 1ns/1ps

module motor_router (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [motion_pkg::NUM_AXES-1:0]     axis_step,
    input  logic [motion_pkg::NUM_AXES-1:0]     axis_dir,
    input  logic [motion_pkg::MOTOR_CFG_W*motion_pkg::NUM_MOTORS-1:0] motor_cfg,
    output logic [motion_pkg::NUM_MOTORS-1:0]   mot_step,
    output logic [motion_pkg::NUM_MOTORS-1:0]   mot_dir,
    output logic [motion_pkg::NUM_MOTORS-1:0]   mot_enable_n
);
    import motion_pkg::*;

    logic [NUM_MOTORS-1:0] step_nxt;
    logic [NUM_MOTORS-1:0] dir_nxt;
    logic [NUM_MOTORS-1:0] enable;

    // Field per motor: bit0 enable, bits 2:1 axis select, bit3 invert
    for (genvar m = 0; m < NUM_MOTORS; m++) begin : g_map
        axis_sel_t sel;
        logic      hit;

        assign sel         = motor_cfg[MOTOR_CFG_W*m+1 +: 2];
        assign hit         = (sel < NUM_AXES);   // Select 3 parks the motor
        assign enable[m]   = motor_cfg[MOTOR_CFG_W*m];
        assign step_nxt[m] = hit && axis_step[sel];
        assign dir_nxt[m]  = (hit && axis_dir[sel]) ^ motor_cfg[MOTOR_CFG_W*m+3];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mot_step     <= '0;
            mot_dir      <= '0;
            mot_enable_n <= '1;      // Drivers off
        end else begin
            mot_step     <= step_nxt;
            mot_dir      <= dir_nxt;
            mot_enable_n <= ~enable;
        end
    end

endmodule

/* design/step_pulse_fsm.sv */
`timescale 1ns/1ps

module step_pulse_fsm (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               step_stb,
    input  logic               step_dir,
    input  motion_pkg::delay_t pre_n,
    input  motion_pkg::delay_t pulse_n,
    input  motion_pkg::delay_t post_n,
    output logic               step,
    output logic               dir,
    output logic               missed
);
    import motion_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        PRE,
        PULSE,
        POST
    } state_t;

    state_t state;
    delay_t cnt;
    logic   last;

    // A zero count still spends one cycle in its phase
    assign last = (cnt <= 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            cnt    <= '0;
            step   <= 1'b0;
            dir    <= 1'b0;
            missed <= 1'b0;
        end else begin
            if (start)
                missed <= 1'b0;
            else if (step_stb && state != IDLE)
                missed <= 1'b1;                // Sticky until next move

            case (state)
                IDLE: begin
                    if (step_stb) begin
                        state <= PRE;
                        cnt   <= pre_n;
                        dir   <= step_dir;     // Settles ahead of the pulse
                    end
                end
                PRE: begin
                    if (last) begin
                        state <= PULSE;
                        cnt   <= pulse_n;
                        step  <= 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                PULSE: begin
                    if (last) begin
                        state <= POST;
                        cnt   <= post_n;
                        step  <= 1'b0;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                POST: begin
                    if (last)
                        state <= IDLE;
                    else
                        cnt <= cnt - 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_step_in_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        step |-> state == PULSE);

endmodule

/* design/step_timer.sv */
`timescale 1ns/1ps

module step_timer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              abort,
    input  motion_pkg::data_t dt,
    input  motion_pkg::data_t steps,
    output logic              tick,
    output logic              busy,
    output logic              done,
    output motion_pkg::data_t remain
);
    import motion_pkg::*;

    logic [DATA_W-1:0] ivl;   // Cycles left in current interval

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ivl    <= '0;
            tick   <= 1'b0;
            busy   <= 1'b0;
            done   <= 1'b0;
            remain <= '0;
        end else begin
            tick <= 1'b0;
            if (abort) begin
                busy <= 1'b0;                 // remain freezes here
            end else if (start && !busy) begin
                ivl    <= dt;
                remain <= steps;
                busy   <= (steps > 0);
                done   <= (steps <= 0);
            end else if (busy) begin
                if (ivl <= 1) begin
                    ivl    <= dt;
                    tick   <= 1'b1;
                    remain <= remain - 1;
                    if (remain == 1) begin
                        busy <= 1'b0;         // Falls with the last tick
                        done <= 1'b1;
                    end
                end else begin
                    ivl <= ivl - 1;
                end
            end
        end
    end

    // Every tick belongs to a running move
    a_tick_in_move: assert property (@(posedge clk) disable iff (!rst_n)
        tick |-> $past(busy));

endmodule

/* project.f */
design/motion_pkg.sv
design/motion_regs.sv
design/step_timer.sv
design/axis_profile.sv
design/step_pulse_fsm.sv
design/motor_router.sv
design/endstop_guard.sv
design/motion_top.sv
test/tb_motion.sv

/* test/tb_motion.sv */
`timescale 1ns/1ps

module tb_motion;
    import motion_pkg::*;

    logic                  clk;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [ADDR_W-1:0]     paddr;
    logic [DATA_W-1:0]     pwdata;
    logic [DATA_W-1:0]     prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  endstop;
    logic [NUM_MOTORS-1:0] mot_step;
    logic [NUM_MOTORS-1:0] mot_dir;
    logic [NUM_MOTORS-1:0] mot_enable_n;

    integer seed = 11004;
    int     errors;
    int     checks;
    int     failed_tests;
    int     test_err0;
    int     cycles;
    int     limit;
    string  cur_test;
    logic   last_err;              // pslverr of the last APB access
    int     move_dt [4];
    int     move_steps [4];
    longint model_pos [NUM_AXES];
    int     model_vel [NUM_AXES];
    int     model_acc [NUM_AXES];
    logic   exp_dir [NUM_AXES][64];
    int     exp_cnt [NUM_AXES];
    logic   obs_dir [NUM_MOTORS][64];
    int     obs_cnt [NUM_MOTORS];
    logic [NUM_MOTORS-1:0] step_prev;

    motion_top uut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // Step edge monitor, dir captured with each pulse
    always @(negedge clk) begin
        for (int m = 0; m < NUM_MOTORS; m++) begin
            if (mot_step[m] && !step_prev[m]) begin
                if (obs_cnt[m] < 64)
                    obs_dir[m][obs_cnt[m]] = mot_dir[m];
                obs_cnt[m]++;
            end
        end
        step_prev = mot_step;
    end

    task apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        last_err = pslverr;
        check_value("pready", 1, pready);
        @(posedge clk);            // Write lands on this edge
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data     = prdata;
        last_err = pslverr;
        check_value("pready", 1, pready);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task check_value(input string item, input logic [63:0] expected, input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch in %s (%s): expected %0h, actual %0h",
                     cur_test, item, expected, actual);
        end
    endtask

    task automatic draw_range(input int lo, input int hi, output int v);
        v = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endtask

    task begin_test(input string name);
        cur_test  = name;
        test_err0 = errors;
    endtask

    task end_test(input int num);
        if (errors != test_err0)
            failed_tests++;
        $display("[%0d] %s: %s", num, cur_test, (errors == test_err0) ? "passed" : "failed");
    endtask

    // Exact 64-bit integration, one crossing per change of the step bit
    task model_ticks(input int n);
        longint old;
        for (int t = 0; t < n; t++) begin
            for (int a = 0; a < NUM_AXES; a++) begin
                old          = model_pos[a];
                model_pos[a] = model_pos[a] + longint'(model_vel[a]);
                if (model_pos[a][STEP_BIT] != old[STEP_BIT]) begin
                    exp_dir[a][exp_cnt[a]] = (model_vel[a] >= 0);
                    exp_cnt[a]++;
                end
                model_vel[a] = model_vel[a] + model_acc[a];
            end
        end
    endtask

    // Returns on the edge where the start write lands
    task load_move(input int idx, input int ticks);
        int span;
        int pre;
        int pul;
        int pst;
        span = (move_dt[idx] - 4) / 3;     // Keeps pre+pulse+post below dt
        draw_range(1, 1 + span, pre);
        draw_range(1, 1 + span, pul);
        draw_range(1, 1 + span, pst);
        apb_write(ADDR_DT, move_dt[idx]);
        apb_write(ADDR_STEPS, move_steps[idx]);
        apb_write(ADDR_PULSE, {8'd0, pst[7:0], pul[7:0], pre[7:0]});
        for (int a = 0; a < NUM_AXES; a++) begin
            model_vel[a] = $random(seed) >>> 1;
            model_acc[a] = $random(seed) >>> 6;
            apb_write(ADDR_VEL_BASE + AXIS_STRIDE * a, model_vel[a]);
            apb_write(ADDR_ACC_BASE + AXIS_STRIDE * a, model_acc[a]);
            exp_cnt[a] = 0;
        end
        for (int m = 0; m < NUM_MOTORS; m++)
            obs_cnt[m] = 0;
        model_ticks(ticks);
        apb_write(ADDR_CTRL, 32'h1);
    endtask

    task wait_done(input int d);
        logic [31:0] st;
        st = '0;
        while (!st[1])
            apb_read(ADDR_CTRL, st);
        repeat (2 * d + 8) @(posedge clk);   // Last pulse drains
    endtask

    initial begin
        logic [7:0]  reg_addr [11];
        logic [31:0] reg_mask [11];
        logic [31:0] reg_val [11];
        logic [31:0] rd;
        logic [31:0] rd2;
        logic [11:0] cfg;
        int          sel [NUM_MOTORS];
        int          inv [NUM_MOTORS];
        int          en [NUM_MOTORS];
        int          es_s;
        int          pol;
        int          n;
        int          want;

        clk = 1'b0;
        rst_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        endstop = 1'b0;
        step_prev = '0;
        errors = 0;
        checks = 0;
        failed_tests = 0;
        cycles = 0;
        limit = 0;
        for (int i = 0; i < 4; i++) begin
            draw_range(4, 20, move_dt[i]);
            draw_range(5, 30, move_steps[i]);
            limit += move_dt[i] * move_steps[i];
        end
        limit = 2 * limit + 2000;
        for (int a = 0; a < NUM_AXES; a++)
            model_pos[a] = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        begin_test("register readback");
        reg_addr[0] = ADDR_DT;
        reg_mask[0] = '1;
        reg_addr[1] = ADDR_STEPS;
        reg_mask[1] = '1;
        reg_addr[2] = ADDR_PULSE;
        reg_mask[2] = 32'h00FF_FFFF;
        reg_addr[3] = ADDR_MOTOR;
        reg_mask[3] = 32'h0000_0FFF;
        reg_addr[4] = ADDR_ENDSTOP;
        reg_mask[4] = 32'h7;              // Guard stays disabled
        for (int a = 0; a < NUM_AXES; a++) begin
            reg_addr[5 + 2 * a] = ADDR_VEL_BASE + AXIS_STRIDE * a;
            reg_addr[6 + 2 * a] = ADDR_ACC_BASE + AXIS_STRIDE * a;
            reg_mask[5 + 2 * a] = '1;
            reg_mask[6 + 2 * a] = '1;
        end
        for (int i = 0; i < 11; i++) begin
            reg_val[i] = $random(seed) & reg_mask[i];
            apb_write(reg_addr[i], reg_val[i]);
        end
        for (int i = 0; i < 11; i++) begin
            apb_read(reg_addr[i], rd);
            check_value($sformatf("reg 0x%02h", reg_addr[i]), reg_val[i], rd);
            check_value("pslverr on mapped read", 0, last_err);
        end
        apb_read(8'h1C, rd);
        check_value("pslverr on read 0x1C", 1, last_err);
        apb_write(8'h60, 32'hFFFF_FFFF);
        check_value("pslverr on write 0x60", 1, last_err);
        apb_read(ADDR_DT, rd);
        check_value("dt after bad write", reg_val[0], rd);
        end_test(1);

        begin_test("move result");
        apb_write(ADDR_MOTOR, 32'h531);   // Motor m follows axis m
        load_move(0, move_steps[0]);
        wait_done(move_dt[0]);
        apb_read(ADDR_REMAIN, rd);
        check_value("remain", 0, rd);
        for (int a = 0; a < NUM_AXES; a++) begin
            apb_read(ADDR_POS_BASE + POS_STRIDE * a, rd);
            check_value($sformatf("pos axis %0d", a), model_pos[a][63:32], rd);
        end
        end_test(2);

        begin_test("step count");
        load_move(1, move_steps[1]);
        wait_done(move_dt[1]);
        apb_read(ADDR_CTRL, rd);
        check_value("missed", 0, rd[3]);
        check_value("busy after done", 0, rd[0]);
        for (int m = 0; m < NUM_MOTORS; m++) begin
            check_value($sformatf("steps motor %0d", m), exp_cnt[m], obs_cnt[m]);
            if (exp_cnt[m] == obs_cnt[m])
                for (int k = 0; k < exp_cnt[m]; k++)
                    check_value($sformatf("dir motor %0d step %0d", m, k),
                                exp_dir[m][k], obs_dir[m][k]);
        end
        end_test(3);

        begin_test("routing");
        for (int m = 0; m < NUM_MOTORS; m++) begin
            draw_range(0, 3, sel[m]);
            draw_range(0, 1, inv[m]);
            draw_range(0, 1, en[m]);
            cfg[4*m +: 4] = {inv[m][0], sel[m][1:0], en[m][0]};
        end
        apb_write(ADDR_MOTOR, cfg);
        load_move(2, move_steps[2]);
        wait_done(move_dt[2]);
        for (int m = 0; m < NUM_MOTORS; m++) begin
            want = (sel[m] < NUM_AXES) ? exp_cnt[sel[m]] : 0;
            check_value($sformatf("steps motor %0d", m), want, obs_cnt[m]);
            if (want == obs_cnt[m])
                for (int k = 0; k < want; k++)
                    check_value($sformatf("dir motor %0d step %0d", m, k),
                                exp_dir[sel[m]][k] ^ inv[m][0], obs_dir[m][k]);
            check_value($sformatf("enable_n motor %0d", m), !en[m][0], mot_enable_n[m]);
        end
        end_test(4);

        begin_test("endstop abort");
        draw_range(0, 2, es_s);
        draw_range(0, 1, pol);
        endstop <= !pol[0];
        repeat (4) @(posedge clk);
        apb_write(ADDR_ENDSTOP, {28'd0, 1'b1, pol[0], es_s[1:0]});
        n = move_steps[3] / 2;
        load_move(3, n);
        // Pin hits on the edge that issues tick n, clear of the next tick
        repeat (1 + n * move_dt[3]) @(posedge clk);
        endstop <= pol[0];
        rd = '0;
        while (!rd[2])
            apb_read(ADDR_CTRL, rd);
        check_value("done while aborted", 0, rd[1]);
        apb_read(ADDR_REMAIN, rd);
        check_value("remain at abort", move_steps[3] - n, rd);
        repeat (3 * move_dt[3]) @(posedge clk);
        apb_read(ADDR_REMAIN, rd2);
        check_value("remain frozen", move_steps[3] - n, rd2);
        apb_read(ADDR_POS_BASE + POS_STRIDE * es_s, rd);
        check_value("pos at abort", model_pos[es_s][63:32], rd);
        apb_read(ADDR_ES_POS, rd2);
        check_value("es_pos", model_pos[es_s][63:32], rd2);
        endstop <= !pol[0];
        repeat (4) @(posedge clk);
        apb_write(ADDR_CTRL, 32'h2);
        apb_read(ADDR_CTRL, rd);
        check_value("aborted after unlock", 0, rd[2]);
        end_test(5);

        $display("Summary: 5 tests, %0d failed, %0d checks, %0d mismatches",
                 failed_tests, checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule
